/* computer_player.sv */
// computer side of the game: strategy register, move cycler and the markov predictor
`timescale 1ns/1ps
`default_nettype none

`include "rps_consts.svh"

module computer_player (
	input  logic                clock,
	input  logic                reset,
	input  logic                play,
	input  logic                load,
	input  game_pkg::strategy_t strategy,
	input  game_pkg::move_t     user_move,
	output game_pkg::move_t     com_move
);
	import game_pkg::*;

	strategy_t strat_q;
	move_t     cyc_move;
	move_t     markov_move;

	// strategy only changes on a load pulse, next play picks it up
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			strat_q <= STRAT_CYCLER;
		end else if (load) begin
			strat_q <= strategy;
		end
	end

	// free-running modulo-3 counter, the "random" player
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			cyc_move <= ROCK;
		end else if (cyc_move == move_t'(`RPS_MOVES - 1)) begin
			cyc_move <= ROCK;
		end else begin
			cyc_move <= move_t'(cyc_move + 2'd1);
		end
	end

	markov_predictor u_markov (
		.clock     (clock),
		.reset     (reset),
		.play      (play),
		.user_move (user_move),
		.com_move  (com_move), // own choice goes back as round context
		.cyc_move  (cyc_move),
		.choice    (markov_move)
	);

	assign com_move = (strat_q == STRAT_MARKOV) ? markov_move : cyc_move;

endmodule

`default_nettype wire

/* game_pkg.sv */
// game types shared by the computer player, the predictor and the scoreboard; compile before them
`default_nettype none

`include "rps_consts.svh"

package game_pkg;

	// encoding kept from the board switches
	typedef enum logic [`RPS_MOVE_W-1:0] {
		ROCK    = 2'd0,
		SCISSOR = 2'd1,
		PAPER   = 2'd2
	} move_t;

	// one-hot when a round has been played, all zero after reset
	typedef struct packed {
		logic user_win;
		logic com_win;
		logic draw;
	} outcome_t;

	typedef enum logic {
		STRAT_CYCLER = `RPS_STRAT_CYCLER,
		STRAT_MARKOV = `RPS_STRAT_MARKOV
	} strategy_t;

	// a round seen as two moves, or as a row of the transition table
	typedef union packed {
		struct packed {
			move_t user; // high half
			move_t com;
		} moves;
		logic [2*`RPS_MOVE_W-1:0] row;
	} round_key_u;

endpackage

`default_nettype wire

/* markov_predictor.sv */
// markov strategy: counts the player's next move per previous round and plays what beats it
`timescale 1ns/1ps
`default_nettype none

`include "rps_consts.svh"

module markov_predictor (
	input  logic             clock,
	input  logic             reset,
	input  logic             play,
	input  game_pkg::move_t  user_move,
	input  game_pkg::move_t  com_move,
	input  game_pkg::move_t  cyc_move,
	output game_pkg::move_t  choice
);
	import game_pkg::*;

	localparam int ROWS = 1 << $bits(round_key_u); // only 9 of the rows are ever addressed

	logic [`RPS_COUNT_W-1:0] counts [0:ROWS-1][0:`RPS_MOVES-1];

	round_key_u cur_key;
	round_key_u prev_key;
	logic       have_prev; // no history before the first round

	logic [`RPS_COUNT_W-1:0] cnt_rock;
	logic [`RPS_COUNT_W-1:0] cnt_scissor;
	logic [`RPS_COUNT_W-1:0] cnt_paper;
	move_t predicted;

	always_comb begin
		cur_key.moves.user = user_move;
		cur_key.moves.com = com_move;
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < `RPS_MOVES; c++) begin
					counts[r][c] <= '0;
				end
			end
			prev_key <= '0;
			have_prev <= 1'b0;
		end else if (play) begin
			if (have_prev) begin
				counts[prev_key.row][user_move] <= counts[prev_key.row][user_move] + 1'b1;
			end
			prev_key <= cur_key; // context for the next round
			have_prev <= 1'b1;
		end
	end

	// row of the previous round
	assign cnt_rock = counts[prev_key.row][ROCK];
	assign cnt_scissor = counts[prev_key.row][SCISSOR];
	assign cnt_paper = counts[prev_key.row][PAPER];

	always_comb begin
		if (cnt_rock == cnt_scissor && cnt_scissor == cnt_paper) begin
			predicted = cyc_move; // no preference, fall back to the cycler
		end else if (cnt_paper >= cnt_rock && cnt_paper >= cnt_scissor) begin
			predicted = PAPER; // paper wins any tie at the top
		end else if (cnt_rock == cnt_scissor) begin
			predicted = cyc_move[0] ? SCISSOR : ROCK;
		end else if (cnt_rock > cnt_scissor) begin
			predicted = ROCK;
		end else begin
			predicted = SCISSOR;
		end
	end

	always_comb begin
		case (predicted)
			ROCK:    choice = PAPER;
			SCISSOR: choice = ROCK;
			default: choice = SCISSOR;
		endcase
	end

endmodule

`default_nettype wire

/* rps_assertions.sv */
// concurrent checks on the scoreboard outcome flags and score steps, bound into scoreboard
`timescale 1ns/1ps
`default_nettype none

module rps_assertions (
	input logic                 clock,
	input logic                 reset,
	input logic                 play,
	input game_pkg::outcome_t   outcome,
	input score_pkg::score_t    user_score,
	input score_pkg::score_t    com_score
);
	import score_pkg::*;

	// never two results at once
	assert property (@(posedge clock) disable iff (!reset) $onehot0(outcome))
		else $error("more than one outcome flag high: %b", outcome);

	assert property (@(posedge clock) disable iff (!reset)
		(user_score != $past(user_score)) |-> ($past(play) && user_score == score_t'($past(user_score) + 1)))
		else $error("player score stepped without play or by more than one");

	assert property (@(posedge clock) disable iff (!reset)
		(com_score != $past(com_score)) |-> ($past(play) && com_score == score_t'($past(com_score) + 1)))
		else $error("computer score stepped without play or by more than one");

endmodule

bind scoreboard rps_assertions u_assertions (
	.clock      (clock),
	.reset      (reset),
	.play       (play),
	.outcome    (outcome),
	.user_score (user_score),
	.com_score  (com_score)
);

`default_nettype wire

/* rps_consts.svh */
// widths, strategy codes and digit patterns for the rock-paper-scissors game, include where needed
`ifndef RPS_CONSTS_SVH
`define RPS_CONSTS_SVH

`define RPS_MOVE_W 2 // rock, scissor, paper fit in two bits
`define RPS_MOVES 3
`define RPS_COUNT_W 8 // transition counters wrap
`define RPS_SCORE_W 8 // scores wrap

`define RPS_STRAT_CYCLER 1'b0
`define RPS_STRAT_MARKOV 1'b1

// active-low segments, bit 6 is segment g
`define RPS_SEG_0 7'b100_0000
`define RPS_SEG_1 7'b111_1001
`define RPS_SEG_2 7'b010_0100
`define RPS_SEG_3 7'b011_0000
`define RPS_SEG_4 7'b001_1001
`define RPS_SEG_5 7'b001_0010
`define RPS_SEG_6 7'b000_0010
`define RPS_SEG_7 7'b111_1000
`define RPS_SEG_8 7'b000_0000
`define RPS_SEG_9 7'b001_1000
`define RPS_SEG_A 7'b000_1000
`define RPS_SEG_B 7'b000_0011
`define RPS_SEG_C 7'b100_0110
`define RPS_SEG_D 7'b010_0001
`define RPS_SEG_E 7'b000_0110
`define RPS_SEG_F 7'b000_1110

`endif

/* rps_game.sv */
// top level of the rock-paper-scissors game: player move in, outcome flags and six digits out
`timescale 1ns/1ps
`default_nettype none

module rps_game (
	input  logic                clock,
	input  logic                reset,
	input  logic                play,
	input  logic                load,
	input  game_pkg::strategy_t strategy,
	input  game_pkg::move_t     user_move,
	output logic                user_win,
	output logic                com_win,
	output logic                draw,
	output score_pkg::seg_t     hex0,
	output score_pkg::seg_t     hex1,
	output score_pkg::seg_t     hex2,
	output score_pkg::seg_t     hex3,
	output score_pkg::seg_t     hex4,
	output score_pkg::seg_t     hex5
);
	import game_pkg::*;

	move_t com_move; // combinational during the play cycle

	score_if disp ();

	computer_player u_computer (
		.clock     (clock),
		.reset     (reset),
		.play      (play),
		.load      (load),
		.strategy  (strategy),
		.user_move (user_move),
		.com_move  (com_move)
	);

	scoreboard u_scoreboard (
		.clock     (clock),
		.reset     (reset),
		.play      (play),
		.user_move (user_move),
		.com_move  (com_move),
		.disp      (disp.source)
	);

	seven_seg_display u_display (
		.disp (disp.sink),
		.hex0 (hex0),
		.hex1 (hex1),
		.hex2 (hex2),
		.hex3 (hex3),
		.hex4 (hex4),
		.hex5 (hex5)
	);

	assign user_win = disp.outcome.user_win;
	assign com_win = disp.outcome.com_win;
	assign draw = disp.outcome.draw;

endmodule

`default_nettype wire

/* rps_testdata.txt */
// columns: command (0 keep, 1 load cycler, 2 load markov), player move (3 random),
// idle gap in cycles (FF random), repeats, expected computer move (3 model), outcome (7 model)
0 0 00 01 1 4
0 0 01 01 0 1
0 1 00 01 0 2
0 2 02 01 2 1
0 2 00 01 0 4
0 1 03 01 2 4
0 0 00 01 1 4
0 3 FF 3C 3 7
0 0 FF 05 3 7
// markov learns a constant player
2 0 02 01 3 7
0 0 FF 28 3 7
0 0 00 01 2 2
0 1 03 01 2 4
0 3 FF 20 3 7
// back to the cycler
1 2 04 01 3 7
0 3 00 30 3 7
0 2 FF 08 3 7
2 1 01 01 3 7
0 1 FF 10 3 7
FF 0 00 00 0 0

/* run_sim.sh */
#!/bin/sh
# build and run the rock-paper-scissors testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rps_game -f vlog.f \
	-o sim_rps > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_rps > sim.log 2>&1 || echo "simulation returned an error"
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* score_if.sv */
// scoreboard state as seen by the display; the scoreboard drives it and the decoder reads it
`timescale 1ns/1ps
`default_nettype none

interface score_if;
	import game_pkg::*;
	import score_pkg::*;

	move_t    user_move;
	move_t    com_move;
	outcome_t outcome;
	score_t   user_score;
	score_t   com_score;

	modport source (output user_move, com_move, outcome, user_score, com_score);
	modport sink (input user_move, com_move, outcome, user_score, com_score);

endinterface

`default_nettype wire

/* score_pkg.sv */
// scoreboard and display types; compile before the interface and the display decoder
`default_nettype none

`include "rps_consts.svh"

package score_pkg;

	typedef logic [`RPS_SCORE_W-1:0] score_t;

	// one hex digit of a score or a move code
	typedef logic [3:0] nibble_t;

	// active low, bit 6 is segment g
	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

/* scoreboard.sv */
// judges each round on play and keeps the moves, outcome flags and both scores for display
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
	input  logic            clock,
	input  logic            reset,
	input  logic            play,
	input  game_pkg::move_t user_move,
	input  game_pkg::move_t com_move,
	score_if.source         disp
);
	import game_pkg::*;
	import score_pkg::*;

	move_t    latched_user;
	move_t    latched_com;
	outcome_t outcome;
	outcome_t verdict;
	score_t   user_score;
	score_t   com_score;

	// true when a beats b
	function automatic logic beats(input move_t a, input move_t b);
		beats = (a == ROCK && b == SCISSOR) ||
			(a == SCISSOR && b == PAPER) ||
			(a == PAPER && b == ROCK);
	endfunction

	always_comb begin
		verdict.user_win = beats(user_move, com_move);
		verdict.com_win = beats(com_move, user_move);
		verdict.draw = (user_move == com_move);
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			latched_user <= ROCK;
			latched_com <= ROCK;
			outcome <= '0;
			user_score <= '0;
			com_score <= '0;
		end else if (play) begin
			latched_user <= user_move;
			latched_com <= com_move;
			outcome <= verdict; // held until the next play
			if (verdict.user_win) begin
				user_score <= user_score + 1'b1;
			end
			if (verdict.com_win) begin
				com_score <= com_score + 1'b1;
			end
		end
	end

	assign disp.user_move = latched_user;
	assign disp.com_move = latched_com;
	assign disp.outcome = outcome;
	assign disp.user_score = user_score;
	assign disp.com_score = com_score;

endmodule

`default_nettype wire

/* seven_seg_display.sv */
// drives the six active-low digits from the scoreboard state: scores in hex and both moves
`timescale 1ns/1ps
`default_nettype none

`include "rps_consts.svh"

module seven_seg_display (
	score_if.sink           disp,
	output score_pkg::seg_t hex0,
	output score_pkg::seg_t hex1,
	output score_pkg::seg_t hex2,
	output score_pkg::seg_t hex3,
	output score_pkg::seg_t hex4,
	output score_pkg::seg_t hex5
);
	import score_pkg::*;

	function automatic seg_t seg_of(input nibble_t value);
		case (value)
			4'h0:    seg_of = `RPS_SEG_0;
			4'h1:    seg_of = `RPS_SEG_1;
			4'h2:    seg_of = `RPS_SEG_2;
			4'h3:    seg_of = `RPS_SEG_3;
			4'h4:    seg_of = `RPS_SEG_4;
			4'h5:    seg_of = `RPS_SEG_5;
			4'h6:    seg_of = `RPS_SEG_6;
			4'h7:    seg_of = `RPS_SEG_7;
			4'h8:    seg_of = `RPS_SEG_8;
			4'h9:    seg_of = `RPS_SEG_9;
			4'hA:    seg_of = `RPS_SEG_A;
			4'hB:    seg_of = `RPS_SEG_B;
			4'hC:    seg_of = `RPS_SEG_C;
			4'hD:    seg_of = `RPS_SEG_D;
			4'hE:    seg_of = `RPS_SEG_E;
			default: seg_of = `RPS_SEG_F;
		endcase
	endfunction

	assign hex0 = seg_of(disp.user_score[3:0]); // player score
	assign hex1 = seg_of(disp.user_score[7:4]);
	assign hex2 = seg_of({{(4 - `RPS_MOVE_W){1'b0}}, disp.user_move});
	assign hex3 = seg_of({{(4 - `RPS_MOVE_W){1'b0}}, disp.com_move});
	assign hex4 = seg_of(disp.com_score[3:0]); // computer score
	assign hex5 = seg_of(disp.com_score[7:4]);

endmodule

`default_nettype wire

/* tb_rps_game.sv */
// simulation top that replays rounds from the test data and checks the game's flags and digits
`timescale 1ns/1ps
`default_nettype none

`include "rps_consts.svh"

module tb_rps_game;
	import game_pkg::*;
	import score_pkg::*;

	localparam int TOKENS = 6; // tokens per data line
	localparam int MAX_LINES = 64;

	logic clock;
	logic reset;
	logic play;
	logic load;
	strategy_t strategy;
	move_t user_move;
	logic user_win;
	logic com_win;
	logic draw;
	seg_t hex0, hex1, hex2, hex3, hex4, hex5;

	logic [7:0] tdata [0:TOKENS*MAX_LINES-1];
	int clk_count;
	int limit_cycles = 0;
	int counts [0:15][0:2]; // model of the transition table
	logic [3:0] prev_row;
	logic have_prev;
	strategy_t model_strat;
	score_t user_score, com_score;
	outcome_t last_outcome;
	move_t last_user, last_com;

	rps_game i_rps_game (
		.clock (clock), .reset (reset), .play (play), .load (load),
		.strategy (strategy), .user_move (user_move),
		.user_win (user_win), .com_win (com_win), .draw (draw),
		.hex0 (hex0), .hex1 (hex1), .hex2 (hex2),
		.hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
	);

	always #10 clock = ~clock; // 20 ns period

	always @(posedge clock or negedge reset) begin
		if (!reset) clk_count <= 0; // edges since release
		else clk_count <= clk_count + 1;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: test did not finish within %0d cycles", limit_cycles);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	function automatic seg_t seg_of_nibble(input logic [3:0] v);
		seg_t table_seg [0:15];
		table_seg = '{`RPS_SEG_0, `RPS_SEG_1, `RPS_SEG_2, `RPS_SEG_3, `RPS_SEG_4, `RPS_SEG_5,
			`RPS_SEG_6, `RPS_SEG_7, `RPS_SEG_8, `RPS_SEG_9, `RPS_SEG_A, `RPS_SEG_B,
			`RPS_SEG_C, `RPS_SEG_D, `RPS_SEG_E, `RPS_SEG_F};
		return table_seg[v];
	endfunction

	function automatic move_t move_from_seg(input seg_t s);
		if (s == `RPS_SEG_0) return ROCK;
		if (s == `RPS_SEG_1) return SCISSOR;
		if (s == `RPS_SEG_2) return PAPER;
		return move_t'(2'd3); // not a move digit
	endfunction

	function automatic move_t beater(input move_t m);
		if (m == ROCK) return PAPER;
		if (m == SCISSOR) return ROCK;
		return SCISSOR;
	endfunction

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		$display("Testbench failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_move(input string name, input move_t got, input move_t exp);
		if (got !== exp) fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_outcome(input string name, input outcome_t got, input outcome_t exp);
		if (got !== exp) fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) fail_value(name, 32'(got), 32'(exp));
	endtask

	task automatic check_display();
		check_outcome("outcome", {user_win, com_win, draw}, last_outcome);
		check_move("hex3 computer move", move_from_seg(hex3), last_com);
		check_seg("hex2", hex2, seg_of_nibble({2'b00, last_user}));
		check_seg("hex0", hex0, seg_of_nibble(user_score[3:0]));
		check_seg("hex1", hex1, seg_of_nibble(user_score[7:4]));
		check_seg("hex4", hex4, seg_of_nibble(com_score[3:0]));
		check_seg("hex5", hex5, seg_of_nibble(com_score[7:4]));
	endtask

	task automatic play_round(input int b, input bit first);
		move_t mv, cyc, pred, exp_com;
		int cr, cs, cp, top, gap;
		if (first && (tdata[b] == 8'h01 || tdata[b] == 8'h02)) begin
			@(posedge clock);
			#1 load = 1'b1;
			strategy = (tdata[b] == 8'h02) ? STRAT_MARKOV : STRAT_CYCLER;
			model_strat = strategy;
			@(posedge clock);
			#1 load = 1'b0;
		end else begin
			@(posedge clock);
			#1;
		end
		mv = (tdata[b+1] == 8'h03) ? move_t'($urandom % 3) : move_t'(tdata[b+1][1:0]);
		cyc = move_t'(clk_count % 3);
		cr = have_prev ? counts[prev_row][0] : 0;
		cs = have_prev ? counts[prev_row][1] : 0;
		cp = have_prev ? counts[prev_row][2] : 0;
		top = (cr > cs) ? cr : cs;
		if (cp > top) top = cp;
		if (cr == top && cs == top && cp == top) begin
			pred = cyc; // every move equally likely
		end else if (cp == top) begin
			pred = PAPER;
		end else if (cr == top && cs == top) begin
			pred = cyc[0] ? SCISSOR : ROCK;
		end else if (cr == top) begin
			pred = ROCK;
		end else begin
			pred = SCISSOR;
		end
		exp_com = (model_strat == STRAT_MARKOV) ? beater(pred) : cyc;
		play = 1'b1;
		user_move = mv;
		@(posedge clock);
		#1 play = 1'b0;
		last_outcome.draw = (mv == exp_com);
		last_outcome.user_win = (exp_com == beater(mv)) ? 1'b0 : (mv == beater(exp_com));
		last_outcome.com_win = (exp_com == beater(mv));
		if (last_outcome.user_win) user_score = user_score + 1'b1;
		if (last_outcome.com_win) com_score = com_score + 1'b1;
		if (have_prev) counts[prev_row][mv] = (counts[prev_row][mv] + 1) % 256;
		prev_row = {mv, exp_com};
		have_prev = 1'b1;
		last_user = mv;
		last_com = exp_com;
		check_display();
		if (tdata[b+4] != 8'h03) check_move("com_move vs data", move_from_seg(hex3),
			move_t'(tdata[b+4][1:0]));
		if (tdata[b+5] != 8'h07) check_outcome("outcome vs data", {user_win, com_win, draw},
			outcome_t'(tdata[b+5][2:0]));
		gap = (tdata[b+2] == 8'hFF) ? int'($urandom % 16) : int'(tdata[b+2]);
		repeat (gap) @(posedge clock);
		#1 check_display(); // results hold while idle
	endtask

	initial begin
		int line;
		int g;
		clock = 1'b0;
		reset = 1'b0;
		play = 1'b0;
		load = 1'b0;
		strategy = STRAT_CYCLER;
		user_move = ROCK;
		void'($urandom(32'h5ca1ae36));
		for (int i = 0; i < TOKENS*MAX_LINES; i++) tdata[i] = 8'hFF;
		$readmemh("rps_testdata.txt", tdata);
		for (int i = 0; i < 16; i++) begin
			for (int j = 0; j < 3; j++) begin
				counts[i][j] = 0;
			end
		end
		prev_row = '0;
		have_prev = 1'b0;
		model_strat = STRAT_CYCLER;
		user_score = '0;
		com_score = '0;
		last_outcome = '0;
		last_user = ROCK;
		last_com = ROCK;
		line = 0;
		g = 50; // margin
		while (line < MAX_LINES && tdata[line*TOKENS] != 8'hFF) begin
			g += int'(tdata[line*TOKENS+3]) *
				((tdata[line*TOKENS+2] == 8'hFF) ? 18 : int'(tdata[line*TOKENS+2]) + 3);
			line++;
		end
		limit_cycles = g;
		repeat (2) @(posedge clock);
		#1 reset = 1'b1;
		check_display(); // reset state
		for (int l = 0; l < line; l++) begin
			for (int r = 0; r < int'(tdata[l*TOKENS+3]); r++) play_round(l*TOKENS, r == 0);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
game_pkg.sv
score_pkg.sv
score_if.sv
markov_predictor.sv
computer_player.sv
scoreboard.sv
seven_seg_display.sv
rps_game.sv
rps_assertions.sv
tb_rps_game.sv
